/* Makefile */
VERILATOR  ?= verilator
TB_TOP     ?= tb_commit_unit
RTL_TOP    ?= commit_unit
FILELIST   ?= compile.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR)

# the log decides the outcome, not the exit code of the binary
run: build
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then \
	  echo "simulation reported errors, see $(LOG)"; exit 1; \
	elif ! grep -q "RESULT: PASS" $(LOG); then \
	  echo "no result line found in $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* arch_rat.sv */
`timescale 1ns/10ps
`default_nettype none

module arch_rat #(
  parameter int COMMIT_WIDTH = 2,
  parameter int PHY_REG_NUM  = 64
) (
  input  wire logic                            clk,
  input  wire logic                            rst_n,
  commit_bus.dst                               cmt,
  input  wire commit_pkg::arch_reg_t           rat_raddr_i,
  output logic [$clog2(PHY_REG_NUM)-1:0]       rat_rdata_o
);

  localparam int PHY_W = $clog2(PHY_REG_NUM);

  logic [PHY_W-1:0]        rat_q [commit_pkg::ARCH_REG_NUM];
  logic [COMMIT_WIDTH-1:0] wr_en;

  // r0 is hardwired, never remapped
  always_comb begin
    for (int i = 0; i < COMMIT_WIDTH; i++) begin
      wr_en[i] = cmt.valid[i] && (cmt.arch_reg[i] != '0);
    end
  end

  // ==================================================
  // table update
  // ==================================================
  // slots written in order so the younger slot lands last
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int r = 0; r < commit_pkg::ARCH_REG_NUM; r++) begin
        rat_q[r] <= PHY_W'(r);
      end
    end else begin
      for (int i = 0; i < COMMIT_WIDTH; i++) begin
        if (wr_en[i]) begin
          rat_q[cmt.arch_reg[i]] <= cmt.phy_reg[i];
        end
      end
    end
  end

  // ==================================================
  // read port
  // ==================================================
  // sees the table as it stood before this edge's writes
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rat_rdata_o <= '0;
    end else begin
      rat_rdata_o <= rat_q[rat_raddr_i];
    end
  end

  // rename must hand out only real physical registers
  for (genvar i = 0; i < COMMIT_WIDTH; i++) begin : g_preg_range
    a_preg_in_range : assert property (
      @(posedge clk) disable iff (!rst_n)
      wr_en[i] |-> (int'(cmt.phy_reg[i]) < PHY_REG_NUM)
    );
  end

endmodule

`default_nettype wire

/* commit_bus.sv */
`timescale 1ns/10ps
`default_nettype none

interface commit_bus #(
  parameter int COMMIT_WIDTH = 2,
  parameter int PHY_REG_NUM  = 64
);

  localparam int PHY_W = $clog2(PHY_REG_NUM);

  // per slot, slot 0 is the oldest
  logic [COMMIT_WIDTH-1:0]                         valid;
  commit_pkg::arch_reg_t [COMMIT_WIDTH-1:0]       arch_reg;
  logic [COMMIT_WIDTH-1:0][PHY_W-1:0]              phy_reg;
  logic [COMMIT_WIDTH-1:0][PHY_W-1:0]              old_phy_reg;

  // slot 0 only
  logic [31:0]        pc;
  logic [31:0]        br_target;
  logic               excp_valid;
  commit_pkg::ecode_t ecode;
  logic               br_redirect;
  logic               ertn;
  logic               refetch;
  logic               idle;

  modport src (
    output valid, arch_reg, phy_reg, old_phy_reg,
    output pc, br_target, excp_valid, ecode, br_redirect, ertn, refetch, idle
  );

  modport dst (
    input valid, arch_reg, phy_reg, old_phy_reg,
    input pc, br_target, excp_valid, ecode, br_redirect, ertn, refetch, idle
  );

endinterface

`default_nettype wire

/* commit_pkg.sv */
`default_nettype none

package commit_pkg;

  // ==================================================
  // architectural state
  // ==================================================
  localparam int ARCH_REG_NUM = 32;

  typedef logic [4:0] arch_reg_t;

  // fetch restart after reset
  localparam logic [31:0] RESET_PC = 32'h1c00_0000;

  // fixed-size instructions
  localparam logic [31:0] INSN_BYTES = 32'd4;

  // ==================================================
  // exception codes
  // ==================================================
  typedef logic [5:0] ecode_t;

  localparam ecode_t ECODE_INT  = 6'h00;
  localparam ecode_t ECODE_PIL  = 6'h01;
  localparam ecode_t ECODE_PIS  = 6'h02;
  localparam ecode_t ECODE_PIF  = 6'h03;
  localparam ecode_t ECODE_PME  = 6'h04;
  localparam ecode_t ECODE_PPI  = 6'h07;
  localparam ecode_t ECODE_ADE  = 6'h08;
  localparam ecode_t ECODE_ALE  = 6'h09;
  localparam ecode_t ECODE_SYS  = 6'h0b;
  localparam ecode_t ECODE_BRK  = 6'h0c;
  localparam ecode_t ECODE_INE  = 6'h0d;
  // refill has its own entry point
  localparam ecode_t ECODE_TLBR = 6'h3f;

  // ==================================================
  // flush causes, listed in no particular priority
  // ==================================================
  typedef enum logic [2:0] {
    FLUSH_NONE    = 3'd0,
    FLUSH_TLBR    = 3'd1,
    FLUSH_EXCP    = 3'd2,
    FLUSH_BRANCH  = 3'd3,
    FLUSH_ERTN    = 3'd4,
    FLUSH_REFETCH = 3'd5,
    FLUSH_IDLE    = 3'd6
  } flush_cause_e;

endpackage

`default_nettype wire

/* commit_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module commit_unit #(
  parameter int COMMIT_WIDTH = 2,
  parameter int PHY_REG_NUM  = 64
) (
  input  wire logic                                                 clk,
  input  wire logic                                                 rst_n,
  // commit beat
  input  wire logic [COMMIT_WIDTH-1:0]                              cmt_valid_i,
  input  wire commit_pkg::arch_reg_t [COMMIT_WIDTH-1:0]             cmt_arch_reg_i,
  input  wire logic [COMMIT_WIDTH-1:0][$clog2(PHY_REG_NUM)-1:0]     cmt_phy_reg_i,
  input  wire logic [COMMIT_WIDTH-1:0][$clog2(PHY_REG_NUM)-1:0]     cmt_old_phy_reg_i,
  input  wire logic [31:0]                                          cmt_pc_i,
  input  wire logic [31:0]                                          cmt_br_target_i,
  input  wire logic                                                 cmt_excp_valid_i,
  input  wire commit_pkg::ecode_t                                   cmt_ecode_i,
  input  wire logic                                                 cmt_br_redirect_i,
  input  wire logic                                                 cmt_ertn_i,
  input  wire logic                                                 cmt_refetch_i,
  input  wire logic                                                 cmt_idle_i,
  // csr side
  input  wire logic                                                 has_int_i,
  input  wire logic [31:0]                                          eentry_i,
  input  wire logic [31:0]                                          tlbrentry_i,
  input  wire logic [31:0]                                          era_i,
  // rename side
  input  wire commit_pkg::arch_reg_t                                rat_raddr_i,
  input  wire logic                                                 alloc_req_i,
  // fetch redirect
  output logic                                                      redirect_valid_o,
  output logic [31:0]                                               redirect_pc_o,
  output commit_pkg::flush_cause_e                                  flush_cause_o,
  output logic                                                      excp_o,
  output logic [31:0]                                               era_o,
  output logic                                                      fetch_hold_o,
  output logic [$clog2(PHY_REG_NUM)-1:0]                            rat_rdata_o,
  output logic                                                      alloc_valid_o,
  output logic [$clog2(PHY_REG_NUM)-1:0]                            alloc_preg_o,
  output logic [$clog2(PHY_REG_NUM-commit_pkg::ARCH_REG_NUM+1)-1:0] free_count_o
);

  commit_bus #(.COMMIT_WIDTH(COMMIT_WIDTH), .PHY_REG_NUM(PHY_REG_NUM)) cmt_bus ();

  // ==================================================
  // drive the bus, src side
  // ==================================================
  assign cmt_bus.valid       = cmt_valid_i;
  assign cmt_bus.arch_reg    = cmt_arch_reg_i;
  assign cmt_bus.phy_reg     = cmt_phy_reg_i;
  assign cmt_bus.old_phy_reg = cmt_old_phy_reg_i;
  assign cmt_bus.pc          = cmt_pc_i;
  assign cmt_bus.br_target   = cmt_br_target_i;
  assign cmt_bus.excp_valid  = cmt_excp_valid_i;
  assign cmt_bus.ecode       = cmt_ecode_i;
  assign cmt_bus.br_redirect = cmt_br_redirect_i;
  assign cmt_bus.ertn        = cmt_ertn_i;
  assign cmt_bus.refetch     = cmt_refetch_i;
  assign cmt_bus.idle        = cmt_idle_i;

  flush_ctrl #(.COMMIT_WIDTH(COMMIT_WIDTH)) u_flush_ctrl (
    .clk              (clk),
    .rst_n            (rst_n),
    .cmt              (cmt_bus.dst),
    .has_int_i        (has_int_i),
    .eentry_i         (eentry_i),
    .tlbrentry_i      (tlbrentry_i),
    .era_i            (era_i),
    .redirect_valid_o (redirect_valid_o),
    .redirect_pc_o    (redirect_pc_o),
    .flush_cause_o    (flush_cause_o),
    .excp_o           (excp_o),
    .era_o            (era_o),
    .fetch_hold_o     (fetch_hold_o)
  );

  arch_rat #(.COMMIT_WIDTH(COMMIT_WIDTH), .PHY_REG_NUM(PHY_REG_NUM)) u_arch_rat (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmt         (cmt_bus.dst),
    .rat_raddr_i (rat_raddr_i),
    .rat_rdata_o (rat_rdata_o)
  );

  free_list #(.COMMIT_WIDTH(COMMIT_WIDTH), .PHY_REG_NUM(PHY_REG_NUM)) u_free_list (
    .clk           (clk),
    .rst_n         (rst_n),
    .cmt           (cmt_bus.dst),
    .alloc_req_i   (alloc_req_i),
    .alloc_valid_o (alloc_valid_o),
    .alloc_preg_o  (alloc_preg_o),
    .free_count_o  (free_count_o)
  );

endmodule

`default_nettype wire

/* compile.f */
commit_pkg.sv
commit_bus.sv
flush_ctrl.sv
arch_rat.sv
free_list.sv
commit_unit.sv
tb_commit_unit.sv

/* flush_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module flush_ctrl #(
  parameter int COMMIT_WIDTH = 2
) (
  input  wire logic                     clk,
  input  wire logic                     rst_n,
  commit_bus.dst                        cmt,
  input  wire logic                     has_int_i,
  input  wire logic [31:0]              eentry_i,
  input  wire logic [31:0]              tlbrentry_i,
  input  wire logic [31:0]              era_i,
  output logic                          redirect_valid_o,
  output logic [31:0]                   redirect_pc_o,
  output commit_pkg::flush_cause_e      flush_cause_o,
  output logic                          excp_o,
  output logic [31:0]                   era_o,
  output logic                          fetch_hold_o
);

  commit_pkg::flush_cause_e cause_n;
  logic [31:0]              target_n;
  logic [31:0]              pc_next;
  logic [31:0]              era_n;
  logic                     excp_n;
  logic                     idle_cmt;

  // slot 0 is the only place a flush can come from
  if (COMMIT_WIDTH < 1) begin : g_width_check
    $error("flush_ctrl needs at least one commit slot");
  end

  assign pc_next = cmt.pc + commit_pkg::INSN_BYTES;

  // ==================================================
  // cause and restart target
  // ==================================================
  always_comb begin
    cause_n  = commit_pkg::FLUSH_NONE;
    target_n = commit_pkg::RESET_PC;
    if (cmt.valid[0]) begin
      if (cmt.excp_valid && cmt.ecode == commit_pkg::ECODE_TLBR) begin
        cause_n  = commit_pkg::FLUSH_TLBR;
        target_n = tlbrentry_i;
      end else if (cmt.excp_valid) begin
        cause_n  = commit_pkg::FLUSH_EXCP;
        target_n = eentry_i;
      end else if (cmt.br_redirect) begin
        cause_n  = commit_pkg::FLUSH_BRANCH;
        target_n = cmt.br_target;
      end else if (cmt.ertn) begin
        cause_n  = commit_pkg::FLUSH_ERTN;
        target_n = era_i;
      end else if (cmt.refetch) begin
        cause_n  = commit_pkg::FLUSH_REFETCH;
        target_n = pc_next;
      end else if (cmt.idle) begin
        cause_n  = commit_pkg::FLUSH_IDLE;
        target_n = pc_next;
      end
    end
  end

  assign excp_n = (cause_n == commit_pkg::FLUSH_TLBR) || (cause_n == commit_pkg::FLUSH_EXCP);

  // syscall and break resume past the trapping instruction
  assign era_n = (cmt.ecode == commit_pkg::ECODE_SYS || cmt.ecode == commit_pkg::ECODE_BRK) ?
                 pc_next : cmt.pc;

  // an idle that traps does not halt fetch
  assign idle_cmt = cmt.valid[0] & cmt.idle & ~cmt.excp_valid;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      redirect_valid_o <= 1'b0;
      redirect_pc_o    <= commit_pkg::RESET_PC;
      flush_cause_o    <= commit_pkg::FLUSH_NONE;
      excp_o           <= 1'b0;
    end else begin
      redirect_valid_o <= (cause_n != commit_pkg::FLUSH_NONE);
      redirect_pc_o    <= target_n;
      flush_cause_o    <= cause_n;
      excp_o           <= excp_n;
    end
  end

  always_ff @(posedge clk) begin
    era_o <= era_n;
  end

  // ==================================================
  // idle lock, released by a pending interrupt
  // ==================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fetch_hold_o <= 1'b0;
    end else if (idle_cmt && !has_int_i) begin
      fetch_hold_o <= 1'b1;
    end else if (has_int_i) begin
      fetch_hold_o <= 1'b0;
    end
  end

  // redirect and lock only ever start from a retiring oldest slot
  a_flush_from_slot0 : assert property (
    @(posedge clk) disable iff (!rst_n)
    ($rose(redirect_valid_o) || $rose(fetch_hold_o)) |-> $past(cmt.valid[0])
  );

endmodule

`default_nettype wire

/* free_list.sv */
`timescale 1ns/10ps
`default_nettype none

module free_list #(
  parameter int COMMIT_WIDTH = 2,
  parameter int PHY_REG_NUM  = 64
) (
  input  wire logic                                                          clk,
  input  wire logic                                                          rst_n,
  commit_bus.dst                                                             cmt,
  input  wire logic                                                          alloc_req_i,
  output logic                                                               alloc_valid_o,
  output logic [$clog2(PHY_REG_NUM)-1:0]                                     alloc_preg_o,
  output logic [$clog2(PHY_REG_NUM-commit_pkg::ARCH_REG_NUM+1)-1:0]          free_count_o
);

  localparam int PHY_W = $clog2(PHY_REG_NUM);
  localparam int DEPTH = PHY_REG_NUM - commit_pkg::ARCH_REG_NUM;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [PHY_W-1:0]        fifo_q [DEPTH];
  logic [PTR_W-1:0]        head_q;
  logic [PTR_W-1:0]        tail_q;
  logic [CNT_W-1:0]        count_q;

  logic                    pop;
  logic [COMMIT_WIDTH-1:0] push_en;
  logic [PTR_W-1:0]        push_ptr [COMMIT_WIDTH];
  logic [PTR_W-1:0]        tail_n;
  logic [CNT_W-1:0]        push_cnt;

  // wrap for depths that are not a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  // ==================================================
  // rename side
  // ==================================================
  assign alloc_valid_o = (count_q != '0);
  assign alloc_preg_o  = fifo_q[head_q];
  assign pop           = alloc_req_i & alloc_valid_o;
  assign free_count_o  = count_q;

  // ==================================================
  // commit side, slot order
  // ==================================================
  always_comb begin
    tail_n   = tail_q;
    push_cnt = '0;
    for (int i = 0; i < COMMIT_WIDTH; i++) begin
      push_en[i]  = cmt.valid[i] && (cmt.arch_reg[i] != '0);
      push_ptr[i] = tail_n;
      if (push_en[i]) begin
        tail_n   = ptr_inc(tail_n);
        push_cnt = push_cnt + 1'b1;
      end
    end
  end

  // starts full with the registers above the identity map
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int e = 0; e < DEPTH; e++) begin
        fifo_q[e] <= PHY_W'(commit_pkg::ARCH_REG_NUM + e);
      end
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= CNT_W'(DEPTH);
    end else begin
      for (int i = 0; i < COMMIT_WIDTH; i++) begin
        if (push_en[i]) begin
          fifo_q[push_ptr[i]] <= cmt.old_phy_reg[i];
        end
      end
      if (pop) begin
        head_q <= ptr_inc(head_q);
      end
      tail_q  <= tail_n;
      count_q <= count_q - CNT_W'(pop) + push_cnt;
    end
  end

  // commit can never return more registers than rename took
  a_no_overflow : assert property (
    @(posedge clk) disable iff (!rst_n)
    int'(count_q) <= DEPTH
  );

endmodule

`default_nettype wire

/* tb_commit_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_commit_unit;

  localparam int N_ROWS      = 12;
  localparam int RST_CYCLES  = 16;
  // rough cycle cost of each test in test order
  localparam int LEN_RESET   = commit_pkg::ARCH_REG_NUM;
  localparam int LEN_TABLE   = N_ROWS + 1;
  localparam int LEN_RAT     = 10;
  localparam int LEN_FREE    = 36;
  localparam int LEN_IDLE    = 9;
  localparam int CYCLE_LIMIT = 2 * (LEN_RESET + LEN_TABLE + LEN_RAT + LEN_FREE + LEN_IDLE)
                               + RST_CYCLES;

  // flags are valid, excp, branch, ertn, refetch, idle from msb down
  // era_pc4 marks rows whose saved era points past the instruction
  typedef struct packed {
    logic [5:0]               flags;
    commit_pkg::ecode_t       ecode;
    commit_pkg::flush_cause_e cause;
    logic                     excp;
    logic                     era_pc4;
  } row_t;

  logic                        clk;
  logic                        rst_n;
  logic [1:0]                  cmt_valid_i;
  commit_pkg::arch_reg_t [1:0] cmt_arch_reg_i;
  logic [1:0][5:0]             cmt_phy_reg_i;
  logic [1:0][5:0]             cmt_old_phy_reg_i;
  logic [31:0]                 cmt_pc_i;
  logic [31:0]                 cmt_br_target_i;
  logic                        cmt_excp_valid_i;
  commit_pkg::ecode_t          cmt_ecode_i;
  logic                        cmt_br_redirect_i;
  logic                        cmt_ertn_i;
  logic                        cmt_refetch_i;
  logic                        cmt_idle_i;
  logic                        has_int_i;
  logic [31:0]                 eentry_i;
  logic [31:0]                 tlbrentry_i;
  logic [31:0]                 era_i;
  commit_pkg::arch_reg_t       rat_raddr_i;
  logic                        alloc_req_i;
  logic                        redirect_valid_o;
  logic [31:0]                 redirect_pc_o;
  commit_pkg::flush_cause_e    flush_cause_o;
  logic                        excp_o;
  logic [31:0]                 era_o;
  logic                        fetch_hold_o;
  logic [5:0]                  rat_rdata_o;
  logic                        alloc_valid_o;
  logic [5:0]                  alloc_preg_o;
  logic [5:0]                  free_count_o;

  row_t       rows [N_ROWS];
  logic [5:0] free_model [$];
  int         seed;
  int         errors = 0;
  int         checks = 0;
  int         tests  = 0;
  int         cycles = 0;

  commit_unit dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  task automatic check(input string what, input logic [31:0] actual, input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      $display("ERR %0t: %s is %h, expected %h", $time, what, actual, expected);
      errors++;
    end
  endtask

  task automatic step_cycle();
    @(posedge clk);
    @(negedge clk);
  endtask

  task automatic clear_beat();
    cmt_valid_i       = '0;
    cmt_arch_reg_i    = '0;
    cmt_phy_reg_i     = '0;
    cmt_old_phy_reg_i = '0;
    cmt_pc_i          = '0;
    cmt_br_target_i   = '0;
    cmt_excp_valid_i  = 1'b0;
    cmt_ecode_i       = commit_pkg::ECODE_INT;
    cmt_br_redirect_i = 1'b0;
    cmt_ertn_i        = 1'b0;
    cmt_refetch_i     = 1'b0;
    cmt_idle_i        = 1'b0;
  endtask

  task automatic end_test(input string name, input int errs_before);
    tests++;
    $display("test %-10s done, %0d errors", name, errors - errs_before);
  endtask

  // freed registers join the model queue in slot order
  task automatic commit_pair(input logic [4:0] a0, input logic [5:0] p0, input logic [5:0] o0,
                             input logic [4:0] a1, input logic [5:0] p1, input logic [5:0] o1);
    cmt_valid_i       = 2'b11;
    cmt_arch_reg_i    = {a1, a0};
    cmt_phy_reg_i     = {p1, p0};
    cmt_old_phy_reg_i = {o1, o0};
    if (a0 != 5'd0) free_model.push_back(o0);
    if (a1 != 5'd0) free_model.push_back(o1);
    step_cycle();
    clear_beat();
    check("free_count", 32'(free_count_o), 32'(free_model.size()));
  endtask

  task automatic pop_expect();
    logic [5:0] want;
    want = free_model.pop_front();
    check("alloc_valid", 32'(alloc_valid_o), 32'd1);
    check("alloc_preg", 32'(alloc_preg_o), 32'(want));
    alloc_req_i = 1'b1;
    step_cycle();
    alloc_req_i = 1'b0;
    check("free_count", 32'(free_count_o), 32'(free_model.size()));
  endtask

  task automatic read_rat(input logic [4:0] r, input logic [5:0] want);
    rat_raddr_i = r;
    step_cycle();
    check($sformatf("rat[%0d]", r), 32'(rat_rdata_o), 32'(want));
  endtask

  // restart address by cause while the beat is still driven
  function automatic logic [31:0] restart_addr(input commit_pkg::flush_cause_e c);
    case (c)
      commit_pkg::FLUSH_TLBR:   return tlbrentry_i;
      commit_pkg::FLUSH_EXCP:   return eentry_i;
      commit_pkg::FLUSH_BRANCH: return cmt_br_target_i;
      commit_pkg::FLUSH_ERTN:   return era_i;
      default:                  return cmt_pc_i + 32'd4;
    endcase
  endfunction

  initial begin
    int          errs;
    logic [31:0] want_era;
    seed     = 32'h9033_7d65;
    rows[0]  = '{6'b111110, commit_pkg::ECODE_TLBR, commit_pkg::FLUSH_TLBR,    1'b1, 1'b0};
    rows[1]  = '{6'b111100, commit_pkg::ECODE_SYS,  commit_pkg::FLUSH_EXCP,    1'b1, 1'b1};
    rows[2]  = '{6'b110000, commit_pkg::ECODE_BRK,  commit_pkg::FLUSH_EXCP,    1'b1, 1'b1};
    rows[3]  = '{6'b110100, commit_pkg::ECODE_ADE,  commit_pkg::FLUSH_EXCP,    1'b1, 1'b0};
    rows[4]  = '{6'b101111, commit_pkg::ECODE_TLBR, commit_pkg::FLUSH_BRANCH,  1'b0, 1'b0};
    rows[5]  = '{6'b100110, commit_pkg::ECODE_INE,  commit_pkg::FLUSH_ERTN,    1'b0, 1'b0};
    rows[6]  = '{6'b100011, commit_pkg::ECODE_SYS,  commit_pkg::FLUSH_REFETCH, 1'b0, 1'b1};
    rows[7]  = '{6'b100001, commit_pkg::ECODE_INT,  commit_pkg::FLUSH_IDLE,    1'b0, 1'b0};
    rows[8]  = '{6'b011111, commit_pkg::ECODE_TLBR, commit_pkg::FLUSH_NONE,    1'b0, 1'b0};
    rows[9]  = '{6'b100000, commit_pkg::ECODE_INT,  commit_pkg::FLUSH_NONE,    1'b0, 1'b0};
    rows[10] = '{6'b110000, commit_pkg::ECODE_INT,  commit_pkg::FLUSH_EXCP,    1'b1, 1'b0};
    rows[11] = '{6'b111001, commit_pkg::ECODE_ALE,  commit_pkg::FLUSH_EXCP,    1'b1, 1'b0};
    rst_n       = 1'b0;
    clear_beat();
    has_int_i   = 1'b0;
    eentry_i    = '0;
    tlbrentry_i = '0;
    era_i       = '0;
    rat_raddr_i = '0;
    alloc_req_i = 1'b0;
    for (int e = 32; e < 64; e++) free_model.push_back(6'(e));
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // ==================================================
    // reset state
    // ==================================================
    errs = errors;
    check("redirect_valid", 32'(redirect_valid_o), 32'd0);
    check("excp", 32'(excp_o), 32'd0);
    check("fetch_hold", 32'(fetch_hold_o), 32'd0);
    check("flush_cause", 32'(flush_cause_o), 32'(commit_pkg::FLUSH_NONE));
    check("free_count", 32'(free_count_o), 32'd32);
    check("alloc_valid", 32'(alloc_valid_o), 32'd1);
    for (int r = 0; r < 32; r++) read_rat(5'(r), 6'(r));
    end_test("reset", errs);

    // ==================================================
    // redirect priority with an interrupt pending so idle rows stay unlocked
    // ==================================================
    errs = errors;
    has_int_i = 1'b1;
    for (int r = 0; r < N_ROWS; r++) begin
      {cmt_excp_valid_i, cmt_br_redirect_i, cmt_ertn_i} = rows[r].flags[4:2];
      {cmt_refetch_i, cmt_idle_i} = rows[r].flags[1:0];
      cmt_valid_i     = {1'b0, rows[r].flags[5]};
      cmt_ecode_i     = rows[r].ecode;
      cmt_pc_i        = $random(seed) & ~32'h3;
      cmt_br_target_i = $random(seed) & ~32'h3;
      eentry_i        = $random(seed) & ~32'h3;
      tlbrentry_i     = $random(seed) & ~32'h3;
      era_i           = $random(seed) & ~32'h3;
      step_cycle();
      check($sformatf("row %0d redirect_valid", r), 32'(redirect_valid_o),
            32'(rows[r].cause != commit_pkg::FLUSH_NONE));
      check($sformatf("row %0d cause", r), 32'(flush_cause_o), 32'(rows[r].cause));
      check($sformatf("row %0d excp", r), 32'(excp_o), 32'(rows[r].excp));
      check($sformatf("row %0d fetch_hold", r), 32'(fetch_hold_o), 32'd0);
      if (rows[r].cause != commit_pkg::FLUSH_NONE) begin
        check($sformatf("row %0d redirect_pc", r), redirect_pc_o, restart_addr(rows[r].cause));
        want_era = rows[r].era_pc4 ? cmt_pc_i + 32'd4 : cmt_pc_i;
        check($sformatf("row %0d era", r), era_o, want_era);
      end
    end
    clear_beat();
    has_int_i = 1'b0;
    step_cycle();
    check("redirect_valid after table", 32'(redirect_valid_o), 32'd0);
    end_test("redirect", errs);

    // ==================================================
    // table update after allocating 32 to 35
    // ==================================================
    errs = errors;
    for (int i = 0; i < 4; i++) pop_expect();
    commit_pair(5'd5, 6'd32, 6'd5, 5'd0, 6'd33, 6'd1);
    commit_pair(5'd7, 6'd34, 6'd7, 5'd7, 6'd35, 6'd34);
    read_rat(5'd5, 6'd32);
    read_rat(5'd0, 6'd0);
    read_rat(5'd7, 6'd35);
    read_rat(5'd6, 6'd6);
    end_test("rat", errs);

    // ==================================================
    // drain the free list then refill and pop
    // ==================================================
    errs = errors;
    while (free_model.size() > 0) pop_expect();
    check("alloc_valid empty", 32'(alloc_valid_o), 32'd0);
    alloc_req_i = 1'b1;
    step_cycle();
    alloc_req_i = 1'b0;
    check("alloc_valid empty", 32'(alloc_valid_o), 32'd0);
    check("free_count empty", 32'(free_count_o), 32'd0);
    commit_pair(5'd9, 6'd36, 6'd9, 5'd10, 6'd37, 6'd10);
    pop_expect();
    pop_expect();
    end_test("free_list", errs);

    // ==================================================
    // idle lock
    // ==================================================
    errs = errors;
    cmt_valid_i = 2'b01;
    cmt_idle_i  = 1'b1;
    cmt_pc_i    = 32'h1c00_0040;
    step_cycle();
    clear_beat();
    check("fetch_hold set", 32'(fetch_hold_o), 32'd1);
    check("idle cause", 32'(flush_cause_o), 32'(commit_pkg::FLUSH_IDLE));
    check("idle redirect_pc", redirect_pc_o, 32'h1c00_0044);
    repeat (4) begin
      step_cycle();
      check("fetch_hold held", 32'(fetch_hold_o), 32'd1);
    end
    has_int_i = 1'b1;
    step_cycle();
    check("fetch_hold released", 32'(fetch_hold_o), 32'd0);
    // idle retiring with the interrupt already pending
    cmt_valid_i = 2'b01;
    cmt_idle_i  = 1'b1;
    step_cycle();
    clear_beat();
    has_int_i = 1'b0;
    check("fetch_hold with int", 32'(fetch_hold_o), 32'd0);
    step_cycle();
    check("fetch_hold stays low", 32'(fetch_hold_o), 32'd0);
    end_test("idle", errs);

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
